// ==== hdl/adc_frontend.sv ====
`timescale 1ns/1ps

`include "afe_config.svh"

module adc_frontend (
  input  logic              adc_clk,
  input  logic              rst_n_i,
  input  afe_pkg::adc_raw_t adc_raw_i [`AFE_NUM_CH],  // From ADC pins
  input  logic              loop_adc_i,               // Take mixer outputs instead
  input  afe_pkg::sample_t  mix_smp_i [`AFE_NUM_CH],
  output afe_pkg::sample_t  adc_smp_o [`AFE_NUM_CH]   // Two's complement samples
);

  localparam int RAW_W = `AFE_ADC_RAW_W;
  localparam int LSB   = `AFE_ADC_RAW_W - `AFE_SAMPLE_W;  // Reserved low bits

  afe_pkg::sample_t adc_conv [`AFE_NUM_CH];

  //////////////////////////////////////////////////
  // Code conversion
  //////////////////////////////////////////////////

  // Negative slope offset binary to two's complement:
  // keep MSB, flip the rest
  for (genvar ch = 0; ch < `AFE_NUM_CH; ch++) begin : g_conv
    assign adc_conv[ch] = {adc_raw_i[ch][RAW_W-1],    // Sign as is
                           ~adc_raw_i[ch][RAW_W-2:LSB]};  // Magnitude inverted
  end

  //////////////////////////////////////////////////
  // Sample register
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int ch = 0; ch < `AFE_NUM_CH; ch++) begin
        adc_smp_o[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < `AFE_NUM_CH; ch++) begin
        // Loopback ignores the pins entirely
        adc_smp_o[ch] <= loop_adc_i ? mix_smp_i[ch] : adc_conv[ch];
      end
    end
  end

endmodule

// ==== hdl/afe_pkg.sv ====
`include "afe_config.svh"

package afe_pkg;

  //////////////////////////////////////////////////
  // Sample types
  //////////////////////////////////////////////////

  // Raw word from the ADC pins
  typedef logic [`AFE_ADC_RAW_W-1:0] adc_raw_t;

  typedef logic signed [`AFE_SAMPLE_W-1:0] sample_t;   // Two's complement
  typedef logic signed [`AFE_SAMPLE_W:0]   mix_sum_t;  // One guard bit for the sum

  // Negative slope, offset binary
  typedef logic [`AFE_SAMPLE_W-1:0] dac_code_t;

  // Bit 0 ADC loopback, bit 1 DAC loopback
  typedef logic [1:0] loop_sel_t;

  //////////////////////////////////////////////////
  // Reset sequencer FSM
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    RST_WAIT_LOCK,  // PLL not locked
    RST_HOLD,       // Locked, counting out the hold
    RST_RUN         // Data path released
  } rst_state_t;

endpackage

// ==== hdl/afe_reset_seq.sv ====
`timescale 1ns/1ps

`include "afe_config.svh"

module afe_reset_seq (
  input  logic adc_clk,
  input  logic arst_n_i,
  input  logic pll_locked_i,
  output logic dp_rst_n_o,    // Data path reset, active low
  output logic dac_rst_o      // DAC reset, active high
);

  localparam int CNT_W = $clog2(`AFE_RST_HOLD + 1);

  afe_pkg::rst_state_t state_q;
  logic [CNT_W-1:0]    hold_cnt;

  //////////////////////////////////////////////////
  // Lock wait and hold FSM
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= afe_pkg::RST_WAIT_LOCK;
      hold_cnt   <= '0;
      dp_rst_n_o <= 1'b0;
    end else if (!pll_locked_i) begin  // Lock lost, start over
      state_q    <= afe_pkg::RST_WAIT_LOCK;
      hold_cnt   <= '0;
      dp_rst_n_o <= 1'b0;
    end else begin
      case (state_q)
        afe_pkg::RST_WAIT_LOCK: begin
          state_q  <= afe_pkg::RST_HOLD;  // Lock seen this cycle
          hold_cnt <= '0;
        end
        afe_pkg::RST_HOLD: begin
          if (hold_cnt == CNT_W'(`AFE_RST_HOLD - 1)) begin
            state_q    <= afe_pkg::RST_RUN;
            dp_rst_n_o <= 1'b1;          // Release after full hold
          end else begin
            hold_cnt <= hold_cnt + 1'b1;
          end
        end
        default: ;  // RST_RUN, stay until lock drops
      endcase
    end
  end

  // DAC reset lags the data path by one cycle
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) dac_rst_o <= 1'b1;
    else           dac_rst_o <= ~dp_rst_n_o;
  end

  // Hold counter stays in range
  a_hold_cnt_range: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    hold_cnt <= CNT_W'(`AFE_RST_HOLD))
    else $error("reset hold counter out of range: %0d", hold_cnt);

endmodule

// ==== hdl/afe_top.sv ====
`timescale 1ns/1ps

`include "afe_config.svh"

module afe_top (
  input  logic               adc_clk,
  input  logic               arst_n_i,
  input  logic               pll_locked_i,
  input  afe_pkg::loop_sel_t loop_sel_i,               // [0] ADC loop, [1] DAC loop
  input  afe_pkg::adc_raw_t  adc_raw_i [`AFE_NUM_CH],
  input  afe_pkg::sample_t   gen_smp_i [`AFE_NUM_CH],  // Generator samples
  input  afe_pkg::sample_t   ctl_smp_i [`AFE_NUM_CH],  // Controller samples
  output afe_pkg::sample_t   adc_o     [`AFE_NUM_CH],
  output afe_pkg::dac_code_t dac_dat_o,
  output logic               dac_sel_o,
  output logic               dac_rst_o
);

  logic             dp_rst_n;                 // Data path reset
  afe_pkg::sample_t adc_smp [`AFE_NUM_CH];
  afe_pkg::sample_t mix_smp [`AFE_NUM_CH];

  //////////////////////////////////////////////////
  // Reset
  //////////////////////////////////////////////////

  afe_reset_seq afe_reset_seq_inst (
    .adc_clk      (adc_clk),
    .arst_n_i     (arst_n_i),
    .pll_locked_i (pll_locked_i),
    .dp_rst_n_o   (dp_rst_n),
    .dac_rst_o    (dac_rst_o)
  );

  //////////////////////////////////////////////////
  // ADC side
  //////////////////////////////////////////////////

  adc_frontend adc_frontend_inst (
    .adc_clk    (adc_clk),
    .rst_n_i    (dp_rst_n),
    .adc_raw_i  (adc_raw_i),
    .loop_adc_i (loop_sel_i[0]),
    .mix_smp_i  (mix_smp),      // ADC loopback source
    .adc_smp_o  (adc_smp)
  );

  assign adc_o = adc_smp;

  //////////////////////////////////////////////////
  // Mixers, one per channel
  //////////////////////////////////////////////////

  for (genvar ch = 0; ch < `AFE_NUM_CH; ch++) begin : g_mix
    channel_mixer channel_mixer_inst (
      .adc_clk   (adc_clk),
      .rst_n_i   (dp_rst_n),
      .gen_smp_i (gen_smp_i[ch]),
      .ctl_smp_i (ctl_smp_i[ch]),
      .mix_smp_o (mix_smp[ch])
    );
  end

  //////////////////////////////////////////////////
  // DAC side
  //////////////////////////////////////////////////

  dac_interleaver dac_interleaver_inst (
    .adc_clk    (adc_clk),
    .rst_n_i    (dp_rst_n),
    .loop_dac_i (loop_sel_i[1]),
    .mix_smp_i  (mix_smp),
    .adc_smp_i  (adc_smp),      // DAC loopback source
    .dac_dat_o  (dac_dat_o),
    .dac_sel_o  (dac_sel_o)
  );

endmodule

// ==== hdl/channel_mixer.sv ====
`timescale 1ns/1ps

`include "afe_config.svh"

module channel_mixer (
  input  logic             adc_clk,
  input  logic             rst_n_i,
  input  afe_pkg::sample_t gen_smp_i,  // Generator sample
  input  afe_pkg::sample_t ctl_smp_i,  // Controller sample
  output afe_pkg::sample_t mix_smp_o   // Saturated sum
);

  localparam int W       = `AFE_SAMPLE_W;
  localparam int SMP_MAX = 2 ** (W - 1) - 1;
  localparam int SMP_MIN = -(2 ** (W - 1));

  afe_pkg::mix_sum_t mix_sum;
  afe_pkg::sample_t  mix_sat;
  logic              sat_ovf;

  // Full precision sum, sign extended
  assign mix_sum = afe_pkg::mix_sum_t'(gen_smp_i) + afe_pkg::mix_sum_t'(ctl_smp_i);

  // Guard bit disagrees with MSB on overflow
  assign sat_ovf = mix_sum[W] ^ mix_sum[W-1];

  // Clamp toward the sign of the true sum
  assign mix_sat = sat_ovf ? {mix_sum[W], {(W-1){~mix_sum[W]}}} : mix_sum[W-1:0];

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) mix_smp_o <= '0;
    else          mix_smp_o <= mix_sat;
  end

  // Arithmetic clamp for cross-checking the bit slicing
  function automatic afe_pkg::sample_t ref_clamp(input int s);
    int c;
    c = s;
    if (c > SMP_MAX) c = SMP_MAX;
    if (c < SMP_MIN) c = SMP_MIN;
    return afe_pkg::sample_t'(c);
  endfunction

  // Output is last cycle's clamped sum
  a_mix_sat: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    $past(rst_n_i) |->
      mix_smp_o == ref_clamp(int'($past(gen_smp_i)) + int'($past(ctl_smp_i))))
    else $error("mixer output %0d does not match clamped sum", mix_smp_o);

endmodule

// ==== hdl/dac_interleaver.sv ====
`timescale 1ns/1ps

`include "afe_config.svh"

module dac_interleaver (
  input  logic               adc_clk,
  input  logic               rst_n_i,
  input  logic               loop_dac_i,               // Send ADC samples to DAC
  input  afe_pkg::sample_t   mix_smp_i [`AFE_NUM_CH],
  input  afe_pkg::sample_t   adc_smp_i [`AFE_NUM_CH],
  output afe_pkg::dac_code_t dac_dat_o,                // Shared DAC bus
  output logic               dac_sel_o                 // High ch0, low ch1
);

  localparam int W = `AFE_SAMPLE_W;

  afe_pkg::sample_t   dac_src  [`AFE_NUM_CH];
  afe_pkg::dac_code_t dac_code [`AFE_NUM_CH];
  logic               phase_q;   // High picks ch0

  initial begin
    assert (`AFE_NUM_CH == 2)
      else $fatal(1, "DAC interleaver needs exactly two channels");
  end

  //////////////////////////////////////////////////
  // Source select and DAC encoding
  //////////////////////////////////////////////////

  for (genvar ch = 0; ch < `AFE_NUM_CH; ch++) begin : g_code
    assign dac_src[ch]  = loop_dac_i ? adc_smp_i[ch] : mix_smp_i[ch];
    // Back to negative slope code
    assign dac_code[ch] = {dac_src[ch][W-1], ~dac_src[ch][W-2:0]};
  end

  //////////////////////////////////////////////////
  // Interleave onto one bus
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q   <= 1'b1;  // First slot after reset is ch0
      dac_sel_o <= 1'b0;
      dac_dat_o <= '0;
    end else begin
      phase_q   <= ~phase_q;
      dac_sel_o <= phase_q;                                // Select travels with data
      dac_dat_o <= phase_q ? dac_code[0] : dac_code[1];
    end
  end

  // Channel select alternates every cycle once running
  a_sel_toggle: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    $past(rst_n_i) |-> dac_sel_o != $past(dac_sel_o))
    else $error("dac_sel_o did not toggle");

endmodule

// ==== include/afe_config.svh ====
`ifndef AFE_CONFIG_SVH
`define AFE_CONFIG_SVH

//////////////////////////////////////////////////
// Data path widths
//////////////////////////////////////////////////

// Raw ADC word, two reserved LSBs included
`define AFE_ADC_RAW_W 16

// Sample and DAC code width
`define AFE_SAMPLE_W 14

//////////////////////////////////////////////////
// Channels and reset timing
//////////////////////////////////////////////////

`define AFE_NUM_CH 2     // Interleaver handles two only

// Cycles of data path reset kept after PLL lock
`define AFE_RST_HOLD 64

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the AFE data path testbench with Verilator

set -u
cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module afe_tb \
  -Mdir "$BUILD_DIR" -o afe_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/afe_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
exit 0

// ==== sim.f ====
+incdir+include
hdl/afe_pkg.sv
hdl/afe_reset_seq.sv
hdl/adc_frontend.sv
hdl/channel_mixer.sv
hdl/dac_interleaver.sv
hdl/afe_top.sv
verification/afe_tb.sv

// ==== verification/afe_tb.sv ====
`timescale 1ns/1ps

`include "afe_config.svh"

module afe_tb;

  localparam int W        = `AFE_SAMPLE_W;
  localparam int RAW_W    = `AFE_ADC_RAW_W;
  localparam int NCH      = `AFE_NUM_CH;
  localparam int HOLD     = `AFE_RST_HOLD;
  localparam int SMP_MAX  = 2 ** (W - 1) - 1;
  localparam int SMP_MIN  = -(2 ** (W - 1));
  localparam int ROW_CYC  = 8;   // Settle cycles per row
  localparam int WAIT_MAX = 16;  // Limit for dac_sel_o waits

  logic               adc_clk;
  logic               arst_n_i;
  logic               pll_locked_i;
  afe_pkg::loop_sel_t loop_sel_i;
  afe_pkg::adc_raw_t  adc_raw_i [NCH];
  afe_pkg::sample_t   gen_smp_i [NCH];
  afe_pkg::sample_t   ctl_smp_i [NCH];
  afe_pkg::sample_t   adc_o     [NCH];
  afe_pkg::dac_code_t dac_dat_o;
  logic               dac_sel_o;
  logic               dac_rst_o;

  int          check_errs;
  int          timeout_errs;
  logic [31:0] rng;  // Xorshift state

  // Stimulus table, channel n in slice n
  string              t_name [$];
  afe_pkg::loop_sel_t t_sel  [$];
  logic [NCH*RAW_W-1:0] t_raw [$];
  logic [NCH*W-1:0]   t_gen  [$];
  logic [NCH*W-1:0]   t_ctl  [$];
  logic [NCH*W-1:0]   t_adc  [$];  // Expected adc_o
  logic [NCH*W-1:0]   t_dac  [$];  // Expected DAC codes

  afe_top afe_top_inst (
    .adc_clk      (adc_clk),
    .arst_n_i     (arst_n_i),
    .pll_locked_i (pll_locked_i),
    .loop_sel_i   (loop_sel_i),
    .adc_raw_i    (adc_raw_i),
    .gen_smp_i    (gen_smp_i),
    .ctl_smp_i    (ctl_smp_i),
    .adc_o        (adc_o),
    .dac_dat_o    (dac_dat_o),
    .dac_sel_o    (dac_sel_o),
    .dac_rst_o    (dac_rst_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;  // 50 MHz
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Reserved LSBs dropped, negative slope code to signed value
  function automatic int adc_to_sample(input int raw);
    return SMP_MAX - (raw >> (RAW_W - W));
  endfunction

  function automatic int clamp_sum(input int a, input int b);
    int s;
    s = a + b;
    if (s > SMP_MAX) s = SMP_MAX;
    if (s < SMP_MIN) s = SMP_MIN;
    return s;
  endfunction

  // Signed value back to negative slope DAC code
  function automatic int sample_to_dac(input int s);
    return SMP_MAX - s;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic int rand_raw();
    logic [31:0] r;
    r = next_rand();
    return int'(r[RAW_W-1:0]);  // Zero extended
  endfunction

  function automatic int rand_sample();
    afe_pkg::sample_t s;
    s = afe_pkg::sample_t'(next_rand());
    return int'(s);             // Sign extended
  endfunction

  //////////////////////////////////////////////////
  // Table construction
  //////////////////////////////////////////////////

  task automatic add_row(input string name, input afe_pkg::loop_sel_t sel,
                         input int raw0, input int raw1, input int gen0, input int gen1,
                         input int ctl0, input int ctl1);
    int                   raw [NCH];
    int                   gen [NCH];
    int                   ctl [NCH];
    int                   mix;
    int                   adc;
    logic [NCH*RAW_W-1:0] raw_w;
    logic [NCH*W-1:0]     gen_w;
    logic [NCH*W-1:0]     ctl_w;
    logic [NCH*W-1:0]     adc_w;
    logic [NCH*W-1:0]     dac_w;
    raw[0] = raw0;
    raw[1] = raw1;
    gen[0] = gen0;
    gen[1] = gen1;
    ctl[0] = ctl0;
    ctl[1] = ctl1;
    for (int ch = 0; ch < NCH; ch++) begin
      mix = clamp_sum(gen[ch], ctl[ch]);
      adc = sel[0] ? mix : adc_to_sample(raw[ch]);  // ADC loopback
      raw_w[ch*RAW_W +: RAW_W] = RAW_W'(raw[ch]);
      gen_w[ch*W +: W] = W'(gen[ch]);
      ctl_w[ch*W +: W] = W'(ctl[ch]);
      adc_w[ch*W +: W] = W'(adc);
      dac_w[ch*W +: W] = W'(sample_to_dac(sel[1] ? adc : mix));  // DAC loopback
    end
    t_name.push_back(name);
    t_sel.push_back(sel);
    t_raw.push_back(raw_w);
    t_gen.push_back(gen_w);
    t_ctl.push_back(ctl_w);
    t_adc.push_back(adc_w);
    t_dac.push_back(dac_w);
  endtask

  task automatic build_table();
    add_row("adc_edges", 2'b00, 'h0000, 'hFFFF, 0, 0, 0, 0);
    add_row("adc_mid", 2'b00, 'h8000, 'h7FFC, 0, 0, 0, 0);
    add_row("adc_lsb_ignored", 2'b00, 'h0003, 'hFFFE, 0, 0, 0, 0);
    for (int i = 0; i < 4; i++) begin
      add_row($sformatf("adc_rand_%0d", i), 2'b00, rand_raw(), rand_raw(), 0, 0, 0, 0);
    end
    add_row("mix_in_range", 2'b00, 0, 0, 1000, -2000, -300, 500);
    add_row("mix_at_max", 2'b00, 0, 0, SMP_MAX, 4095, 0, 4096);
    add_row("mix_at_min", 2'b00, 0, 0, SMP_MIN, -4096, 0, -4096);
    add_row("mix_over_max", 2'b00, 0, 0, SMP_MAX, 5000, 1, 5000);
    add_row("mix_under_min", 2'b00, 0, 0, SMP_MIN, SMP_MIN, -1, SMP_MIN);
    for (int i = 0; i < 4; i++) begin
      add_row($sformatf("mix_rand_%0d", i), 2'b00, 0, 0,
              rand_sample(), rand_sample(), rand_sample(), rand_sample());
    end
    add_row("adc_loop_sat", 2'b01, rand_raw(), rand_raw(), 6000, -6000, 6000, -6000);
    for (int i = 0; i < 2; i++) begin
      add_row($sformatf("adc_loop_rand_%0d", i), 2'b01, rand_raw(), rand_raw(),
              rand_sample(), rand_sample(), rand_sample(), rand_sample());
      add_row($sformatf("dac_loop_rand_%0d", i), 2'b10, rand_raw(), rand_raw(),
              rand_sample(), rand_sample(), rand_sample(), rand_sample());
    end
    add_row("both_loops", 2'b11, rand_raw(), rand_raw(), 3000, -100, 200, -7000);
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [W-1:0] exp,
                           input logic [W-1:0] got);
    assert (got === exp) else begin
      check_errs++;
      $display("CHECK FAILED %s: expected 0x%h actual 0x%h", name, exp, got);
    end
  endtask

  // Counts falling edges until the DAC leaves reset
  task automatic wait_release(input string name);
    int cyc;
    cyc = 0;
    while (dac_rst_o !== 1'b0 && cyc < HOLD + 16) begin
      @(negedge adc_clk);
      cyc++;
    end
    assert (dac_rst_o === 1'b0) else begin
      timeout_errs++;
      $display("Timeout in %s: dac_rst_o never went low", name);
    end
    assert (cyc >= HOLD && cyc <= HOLD + 4) else begin
      check_errs++;
      $display("CHECK FAILED %s: expected %0d to %0d cycles actual %0d",
               name, HOLD, HOLD + 4, cyc);
    end
  endtask

  task automatic run_row(input int i);
    logic [NCH*RAW_W-1:0] raw_w;
    logic [NCH*W-1:0]     gen_w;
    logic [NCH*W-1:0]     ctl_w;
    logic [NCH*W-1:0]     adc_w;
    logic [NCH*W-1:0]     dac_w;
    int                   cyc;
    raw_w = t_raw[i];
    gen_w = t_gen[i];
    ctl_w = t_ctl[i];
    adc_w = t_adc[i];
    dac_w = t_dac[i];
    loop_sel_i = t_sel[i];
    for (int ch = 0; ch < NCH; ch++) begin
      adc_raw_i[ch] = raw_w[ch*RAW_W +: RAW_W];
      gen_smp_i[ch] = gen_w[ch*W +: W];
      ctl_smp_i[ch] = ctl_w[ch*W +: W];
    end
    repeat (ROW_CYC) @(negedge adc_clk);
    for (int ch = 0; ch < NCH; ch++) begin
      check_val($sformatf("%s adc_o[%0d]", t_name[i], ch), adc_w[ch*W +: W], adc_o[ch]);
    end
    cyc = 0;
    while (dac_sel_o !== 1'b1 && cyc < WAIT_MAX) begin
      @(negedge adc_clk);
      cyc++;
    end
    assert (dac_sel_o === 1'b1) else begin
      timeout_errs++;
      $display("Timeout in %s: dac_sel_o never went high", t_name[i]);
      return;
    end
    check_val({t_name[i], " dac ch0"}, dac_w[0 +: W], dac_dat_o);
    cyc = 0;
    do begin
      @(negedge adc_clk);
      cyc++;
    end while (dac_sel_o !== 1'b0 && cyc < WAIT_MAX);
    assert (dac_sel_o === 1'b0) else begin
      timeout_errs++;
      $display("Timeout in %s: dac_sel_o never went low", t_name[i]);
      return;
    end
    assert (cyc == 1) else begin  // Must alternate every cycle
      check_errs++;
      $display("CHECK FAILED %s dac_sel_o high cycles: expected 1 actual %0d",
               t_name[i], cyc);
    end
    check_val({t_name[i], " dac ch1"}, dac_w[W +: W], dac_dat_o);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    arst_n_i     = 1'b0;
    pll_locked_i = 1'b0;
    loop_sel_i   = '0;
    for (int ch = 0; ch < NCH; ch++) begin
      adc_raw_i[ch] = '0;
      gen_smp_i[ch] = '0;
      ctl_smp_i[ch] = '0;
    end
    check_errs   = 0;
    timeout_errs = 0;
    rng          = 32'd50897;
    build_table();
    repeat (10) @(negedge adc_clk);
    arst_n_i = 1'b1;
    repeat (8) begin  // No lock yet
      @(negedge adc_clk);
      check_val("rst_no_lock dac_rst_o", W'(1), W'(dac_rst_o));
      check_val("rst_no_lock dac_sel_o", W'(0), W'(dac_sel_o));
      check_val("rst_no_lock dac_dat_o", W'(0), dac_dat_o);
      for (int ch = 0; ch < NCH; ch++) begin
        check_val($sformatf("rst_no_lock adc_o[%0d]", ch), W'(0), adc_o[ch]);
      end
    end
    pll_locked_i = 1'b1;
    wait_release("rst_first_lock");
    @(negedge adc_clk);
    pll_locked_i = 1'b0;  // Lock lost
    repeat (3) @(negedge adc_clk);
    check_val("rst_lock_lost dac_rst_o", W'(1), W'(dac_rst_o));
    pll_locked_i = 1'b1;
    wait_release("rst_relock");
    for (int i = 0; i < t_name.size(); i++) begin
      run_row(i);
    end
    $display("Errors: %0d check, %0d timeout", check_errs, timeout_errs);
    if (check_errs == 0 && timeout_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
